//--- common/a2_audio_pkg.sv
// ==============================
// Apple II audio package
// Constants, soft-switch addresses and the
// packed records shared by the bus snoop,
// speaker shaping and audio mixer blocks
// ==============================

package a2_audio_pkg;

    // Audio sample rate divider, 27 MHz pixel clock / 44.1 kHz
    localparam int AUDIO_TICK_DIV = 612;
    localparam int TICK_CNT_W = $clog2(AUDIO_TICK_DIV);

    // Speaker pulse length in audio ticks
    localparam logic [7:0] SPEAKER_PULSE_LEN = 8'd255;

    // Speaker contribution to each channel, bit 13
    localparam logic [15:0] SPEAKER_LEVEL = 16'd8192;

    // Credit flow control towards the HDMI sink
    localparam int CREDIT_MAX = 4;
    localparam int CREDIT_W = $clog2(CREDIT_MAX + 1);

    // Mixer sample queue
    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

    // Soft-switch addresses, the "set" switch sits at address + 1
    localparam logic [15:0] ADDR_SPEAKER    = 16'hC030;
    localparam logic [15:0] ADDR_TXTCLR     = 16'hC050;
    localparam logic [15:0] ADDR_MIXCLR     = 16'hC052;
    localparam logic [15:0] ADDR_PAGE1      = 16'hC054;
    localparam logic [15:0] ADDR_LORES      = 16'hC056;
    localparam logic [15:0] ADDR_AN3CLR     = 16'hC05E;
    localparam logic [15:0] ADDR_80STOREOFF = 16'hC000;

    // One snooped, already synchronized bus access
    typedef struct packed {
        logic        valid;
        logic [15:0] addr;
        logic        rw_n;
        logic        m2sel_n;
    } a2_bus_access_t;

    // Video soft-switch state
    typedef struct packed {
        logic text;
        logic mixed;
        logic page2;
        logic hires;
        logic an3;
        logic store80;
    } softswitch_t;

    // Mockingboard stereo sample
    typedef struct packed {
        logic [9:0] left;
        logic [9:0] right;
    } mb_audio_t;

    // HDMI stereo sample word
    typedef struct packed {
        logic [15:0] left;
        logic [15:0] right;
    } audio_sample_t;

endpackage

//--- hw/a2_bus_decode.sv
// ==============================
// Apple II bus decode
// Tracks the video soft switches and the
// speaker toggle from snooped bus accesses
// ==============================

`timescale 1ns/10ps

module a2_bus_decode (
    input  logic                        clk_pixel_w,
    input  logic                        system_reset_n_w,
    input  a2_audio_pkg::a2_bus_access_t bus_access_i,
    output a2_audio_pkg::softswitch_t    softswitch_o,
    output logic                        speaker_bit_o
);

    a2_audio_pkg::softswitch_t sw_q;
    logic                      speaker_q;
    logic                      hit;
    logic [15:0]               pair_addr;
    logic                      set_bit;

    // Only accesses with m2sel_n low reach the IO page
    assign hit = bus_access_i.valid && !bus_access_i.m2sel_n;

    // Switches come in clear/set pairs, address bit 0 picks the action
    assign pair_addr = {bus_access_i.addr[15:1], 1'b0};
    assign set_bit   = bus_access_i.addr[0];

    always_ff @(posedge clk_pixel_w or negedge system_reset_n_w) begin
        if (!system_reset_n_w) begin
            speaker_q <= 1'b0;
        end else if (hit && (bus_access_i.addr == a2_audio_pkg::ADDR_SPEAKER)) begin
            // Any access to $C030 flips the speaker, read or write
            speaker_q <= ~speaker_q;
        end
    end

    always_ff @(posedge clk_pixel_w or negedge system_reset_n_w) begin
        if (!system_reset_n_w) begin
            sw_q <= '0;
        end else if (hit) begin
            case (pair_addr)
                a2_audio_pkg::ADDR_TXTCLR: begin
                    sw_q.text <= set_bit;
                end
                a2_audio_pkg::ADDR_MIXCLR: begin
                    sw_q.mixed <= set_bit;
                end
                a2_audio_pkg::ADDR_PAGE1: begin
                    sw_q.page2 <= set_bit;
                end
                a2_audio_pkg::ADDR_LORES: begin
                    sw_q.hires <= set_bit;
                end
                a2_audio_pkg::ADDR_AN3CLR: begin
                    sw_q.an3 <= set_bit;
                end
                a2_audio_pkg::ADDR_80STOREOFF: begin
                    // 80STORE only responds to writes, reads are keyboard data
                    if (!bus_access_i.rw_n) begin
                        sw_q.store80 <= set_bit;
                    end
                end
                default: begin
                    sw_q <= sw_q;
                end
            endcase
        end
    end

    assign softswitch_o  = sw_q;
    assign speaker_bit_o = speaker_q;

endmodule

//--- speaker/speaker_pulse.sv
// ==============================
// Speaker pulse shaper
// Divides the pixel clock down to the audio
// sample tick and turns speaker toggles into
// a pulse of limited length
// ==============================

`timescale 1ns/10ps

module speaker_pulse (
    input  logic clk_pixel_w,
    input  logic system_reset_n_w,
    input  logic speaker_bit_i,
    output logic audio_tick_o,
    output logic speaker_level_o
);

    localparam logic [a2_audio_pkg::TICK_CNT_W-1:0] TICK_LAST =
        a2_audio_pkg::TICK_CNT_W'(a2_audio_pkg::AUDIO_TICK_DIV - 1);

    logic [a2_audio_pkg::TICK_CNT_W-1:0] div_q;
    logic                                tick_q;
    logic [7:0]                          pulse_cnt_q;
    logic                                prev_bit_q;
    logic                                level_q;

    // Sample rate divider, tick is registered so the first one
    // lands a full divide period after reset
    always_ff @(posedge clk_pixel_w or negedge system_reset_n_w) begin
        if (!system_reset_n_w) begin
            div_q  <= '0;
            tick_q <= 1'b0;
        end else begin
            if (div_q == TICK_LAST) begin
                div_q <= '0;
            end else begin
                div_q <= div_q + 1'b1;
            end
            tick_q <= (div_q == TICK_LAST);
        end
    end

    // A held-high speaker must not leave a DC offset on the audio,
    // so the level drops once the counter runs out
    always_ff @(posedge clk_pixel_w or negedge system_reset_n_w) begin
        if (!system_reset_n_w) begin
            pulse_cnt_q <= '0;
            prev_bit_q  <= 1'b0;
            level_q     <= 1'b0;
        end else if (tick_q) begin
            if (speaker_bit_i != prev_bit_q) begin
                pulse_cnt_q <= a2_audio_pkg::SPEAKER_PULSE_LEN;
            end else if (pulse_cnt_q != 8'd0) begin
                pulse_cnt_q <= pulse_cnt_q - 8'd1;
            end
            // Uses the pre-tick values, so the level lags by one tick
            level_q    <= prev_bit_q && (pulse_cnt_q != 8'd0);
            prev_bit_q <= speaker_bit_i;
        end
    end

    assign audio_tick_o    = tick_q;
    assign speaker_level_o = level_q;

endmodule

//--- hw/audio_mixer.sv
// ==============================
// Audio mixer
// Mixes speaker and Mockingboard audio into
// 16-bit stereo words, queues them and sends
// them to the HDMI sink under credits
// ==============================

`timescale 1ns/10ps

module audio_mixer (
    input  logic                        clk_pixel_w,
    input  logic                        system_reset_n_w,
    input  logic                        audio_tick_i,
    input  logic                        speaker_level_i,
    input  a2_audio_pkg::mb_audio_t     mb_audio_i,
    output a2_audio_pkg::audio_sample_t sample_o,
    output logic                        sample_valid_o,
    input  logic                        credit_return_i,
    output logic                        overflow_o
);

    a2_audio_pkg::audio_sample_t         word_q;
    logic                                push_q;
    a2_audio_pkg::audio_sample_t         queue_mem [a2_audio_pkg::QUEUE_DEPTH];
    logic [a2_audio_pkg::QUEUE_PTR_W-1:0] wr_ptr_q;
    logic [a2_audio_pkg::QUEUE_PTR_W-1:0] rd_ptr_q;
    logic [a2_audio_pkg::QUEUE_CNT_W-1:0] count_q;
    logic [a2_audio_pkg::CREDIT_W-1:0]    credit_q;
    logic                                overflow_q;
    logic                                full;
    logic                                push;
    logic                                send;
    logic [15:0]                         spk_add;

    assign spk_add = speaker_level_i ? a2_audio_pkg::SPEAKER_LEVEL : 16'd0;
    assign full    = (count_q == a2_audio_pkg::QUEUE_CNT_W'(a2_audio_pkg::QUEUE_DEPTH));
    assign push    = push_q && !full;
    assign send    = (count_q != '0) && (credit_q != '0);

    // Mixed word is formed on the tick and queued one cycle later
    always_ff @(posedge clk_pixel_w) begin
        if (audio_tick_i) begin
            word_q.left  <= {2'b00, mb_audio_i.left, 4'b0000} + spk_add;
            word_q.right <= {2'b00, mb_audio_i.right, 4'b0000} + spk_add;
        end
        if (push) begin
            queue_mem[wr_ptr_q] <= word_q;
        end
    end

    always_ff @(posedge clk_pixel_w or negedge system_reset_n_w) begin
        if (!system_reset_n_w) begin
            push_q     <= 1'b0;
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            count_q    <= '0;
            credit_q   <= a2_audio_pkg::CREDIT_W'(a2_audio_pkg::CREDIT_MAX);
            overflow_q <= 1'b0;
        end else begin
            push_q <= audio_tick_i;
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (send) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            count_q  <= count_q + push - send;
            // One credit spent per word sent, one regained per return pulse
            credit_q <= credit_q - send + credit_return_i;
            // Word dropped on a full queue, flag stays until reset
            if (push_q && full) begin
                overflow_q <= 1'b1;
            end
        end
    end

    assign sample_o       = queue_mem[rd_ptr_q];
    assign sample_valid_o = send;
    assign overflow_o     = overflow_q;

endmodule

//--- hw/a2_audio_top.sv
// ==============================
// Apple II audio top level
// Bus snoop, speaker shaping and mixer
// ==============================

`timescale 1ns/10ps

module a2_audio_top (
    input  logic                         clk_pixel_w,
    input  logic                         system_reset_n_w,
    input  a2_audio_pkg::a2_bus_access_t bus_access_i,
    input  a2_audio_pkg::mb_audio_t      mb_audio_i,
    output a2_audio_pkg::softswitch_t    softswitch_o,
    output a2_audio_pkg::audio_sample_t  sample_o,
    output logic                         sample_valid_o,
    input  logic                         credit_return_i,
    output logic                         overflow_o
);

    logic speaker_bit_w;
    logic audio_tick_w;
    logic speaker_level_w;

    a2_bus_decode i_a2_bus_decode (
        .clk_pixel_w      (clk_pixel_w),
        .system_reset_n_w (system_reset_n_w),
        .bus_access_i     (bus_access_i),
        .softswitch_o     (softswitch_o),
        .speaker_bit_o    (speaker_bit_w)
    );

    speaker_pulse i_speaker_pulse (
        .clk_pixel_w      (clk_pixel_w),
        .system_reset_n_w (system_reset_n_w),
        .speaker_bit_i    (speaker_bit_w),
        .audio_tick_o     (audio_tick_w),
        .speaker_level_o  (speaker_level_w)
    );

    audio_mixer i_audio_mixer (
        .clk_pixel_w      (clk_pixel_w),
        .system_reset_n_w (system_reset_n_w),
        .audio_tick_i     (audio_tick_w),
        .speaker_level_i  (speaker_level_w),
        .mb_audio_i       (mb_audio_i),
        .sample_o         (sample_o),
        .sample_valid_o   (sample_valid_o),
        .credit_return_i  (credit_return_i),
        .overflow_o       (overflow_o)
    );

endmodule

//--- test/a2_audio_props.sv
// ==============================
// Audio mixer properties
// Credit and overflow rules on the
// sample interface of the mixer
// ==============================

`timescale 1ns/10ps

module a2_audio_props (
    input logic                              clk_pixel_w,
    input logic                              system_reset_n_w,
    input logic                              sample_valid_i,
    input logic                              credit_return_i,
    input logic [a2_audio_pkg::CREDIT_W-1:0] credit_i,
    input logic                              overflow_i
);

    int fail_count = 0;

    logic [a2_audio_pkg::CREDIT_W-1:0] credit_seen_q;

    // Credits as seen on the interface, words sent against sink returns
    always_ff @(posedge clk_pixel_w or negedge system_reset_n_w) begin
        if (!system_reset_n_w) begin
            credit_seen_q <= a2_audio_pkg::CREDIT_W'(a2_audio_pkg::CREDIT_MAX);
        end else begin
            credit_seen_q <= credit_seen_q - sample_valid_i + credit_return_i;
        end
    end

    // A word only leaves against a credit
    valid_needs_credit: assert property (
        @(posedge clk_pixel_w) disable iff (!system_reset_n_w)
        sample_valid_i |-> (credit_seen_q != '0)
    ) else begin
        $error("sample_valid_o high with no credit left");
        fail_count++;
    end

    credit_in_range: assert property (
        @(posedge clk_pixel_w) disable iff (!system_reset_n_w)
        credit_i <= a2_audio_pkg::CREDIT_MAX
    ) else begin
        $error("credit count above the sink grant");
        fail_count++;
    end

    // Sticky until reset
    overflow_sticky: assert property (
        @(posedge clk_pixel_w) disable iff (!system_reset_n_w)
        overflow_i |=> overflow_i
    ) else begin
        $error("overflow flag cleared without reset");
        fail_count++;
    end

endmodule

bind audio_mixer a2_audio_props i_a2_audio_props (
    .clk_pixel_w      (clk_pixel_w),
    .system_reset_n_w (system_reset_n_w),
    .sample_valid_i   (sample_valid_o),
    .credit_return_i  (credit_return_i),
    .credit_i         (credit_q),
    .overflow_i       (overflow_o)
);

//--- test/tb_a2_audio.sv
// ==============================
// Apple II audio testbench
// Directed tests for the soft switches,
// speaker pulse shaping and the credit
// based sample path into a sink model
// ==============================

`timescale 1ns/10ps

module tb_a2_audio;

    localparam int CLK_PERIOD = 40;
    // Ticks spent by the Mockingboard, speaker and back-pressure tests
    localparam int TEST_TICKS = 9 + 295 + 12;
    localparam int MARGIN_TICKS = 24;
    localparam longint WATCHDOG_NS =
        longint'(TEST_TICKS + MARGIN_TICKS) * a2_audio_pkg::AUDIO_TICK_DIV * CLK_PERIOD;

    logic                         clk_pixel_w = 1'b0;
    logic                         system_reset_n_w = 1'b0;
    a2_audio_pkg::a2_bus_access_t bus_access_i = '0;
    a2_audio_pkg::mb_audio_t      mb_audio_i = '0;
    logic                         credit_return_i = 1'b0;
    a2_audio_pkg::softswitch_t    softswitch_o;
    a2_audio_pkg::audio_sample_t  sample_o;
    logic                         sample_valid_o;
    logic                         overflow_o;

    // Sink model state
    a2_audio_pkg::audio_sample_t rx_q[$];
    logic                        stall_credits = 1'b0;
    int                          pending_credits = 0;

    // Speaker reference model, stepped once per audio tick
    logic spk_bit_m = 1'b0;
    logic prev_bit_m = 1'b0;
    logic level_m = 1'b0;
    int   pulse_cnt_m = 0;

    a2_audio_pkg::mb_audio_t mb_cur = '0;
    int                      seed = 37;
    int                      errors = 0;

    a2_audio_top i_a2_audio_top (
        .clk_pixel_w      (clk_pixel_w),
        .system_reset_n_w (system_reset_n_w),
        .bus_access_i     (bus_access_i),
        .mb_audio_i       (mb_audio_i),
        .softswitch_o     (softswitch_o),
        .sample_o         (sample_o),
        .sample_valid_o   (sample_valid_o),
        .credit_return_i  (credit_return_i),
        .overflow_o       (overflow_o)
    );

    always #(CLK_PERIOD / 2) clk_pixel_w = ~clk_pixel_w;

    // HDMI sink, records each word and hands its credit back unless stalled
    always @(posedge clk_pixel_w) begin : sink_model
        int owed;
        if (!system_reset_n_w) begin
            pending_credits <= 0;
            credit_return_i <= 1'b0;
        end else begin
            owed = pending_credits + (sample_valid_o ? 1 : 0);
            if (sample_valid_o) begin
                rx_q.push_back(sample_o);
            end
            if (!stall_credits && owed > 0) begin
                credit_return_i <= 1'b1;
                owed = owed - 1;
            end else begin
                credit_return_i <= 1'b0;
            end
            pending_credits <= owed;
        end
    end

    function automatic a2_audio_pkg::mb_audio_t next_mb();
        logic [31:0] r;
        r = $random(seed);
        return r[19:0];
    endfunction

    // Expected word: sample scaled up by 4 bits with the speaker on top
    function automatic a2_audio_pkg::audio_sample_t mixed_word(
        input a2_audio_pkg::mb_audio_t mb, input logic spk);
        a2_audio_pkg::audio_sample_t w;
        logic [15:0]                 spk_add;
        spk_add = spk ? a2_audio_pkg::SPEAKER_LEVEL : 16'd0;
        w.left  = ({6'd0, mb.left} << 4) + spk_add;
        w.right = ({6'd0, mb.right} << 4) + spk_add;
        return w;
    endfunction

    function automatic logic [15:0] switch_base(input int idx);
        case (idx)
            0: return a2_audio_pkg::ADDR_TXTCLR;
            1: return a2_audio_pkg::ADDR_MIXCLR;
            2: return a2_audio_pkg::ADDR_PAGE1;
            3: return a2_audio_pkg::ADDR_LORES;
            default: return a2_audio_pkg::ADDR_AN3CLR;
        endcase
    endfunction

    // Level follows the pre-tick bit and counter, so it lags one tick
    task automatic step_speaker_model();
        logic next_level;
        next_level = prev_bit_m && (pulse_cnt_m != 0);
        if (spk_bit_m != prev_bit_m) begin
            pulse_cnt_m = a2_audio_pkg::SPEAKER_PULSE_LEN;
        end else if (pulse_cnt_m != 0) begin
            pulse_cnt_m = pulse_cnt_m - 1;
        end
        level_m    = next_level;
        prev_bit_m = spk_bit_m;
    endtask

    task automatic check_softswitch(input a2_audio_pkg::softswitch_t got,
                                    input a2_audio_pkg::softswitch_t exp, input string msg);
        if (got !== exp) begin
            $display("ERR %0t: %s softswitch %b, expected %b", $time, msg, got, exp);
            errors++;
        end
    endtask

    task automatic check_sample(input a2_audio_pkg::audio_sample_t got,
                                input a2_audio_pkg::audio_sample_t exp,
                                input logic exp_ovf, input string msg);
        if (got !== exp || overflow_o !== exp_ovf) begin
            $display("ERR %0t: %s word %h overflow %b, expected %h overflow %b",
                     $time, msg, got, overflow_o, exp, exp_ovf);
            errors++;
        end
    endtask

    // One bus cycle, then one more so the registered result is visible
    task automatic apply_access(input logic [15:0] addr, input logic rw_n,
                                input logic m2sel_n);
        a2_audio_pkg::a2_bus_access_t acc;
        acc.valid   = 1'b1;
        acc.addr    = addr;
        acc.rw_n    = rw_n;
        acc.m2sel_n = m2sel_n;
        @(posedge clk_pixel_w);
        bus_access_i <= acc;
        @(posedge clk_pixel_w);
        bus_access_i <= '0;
        @(posedge clk_pixel_w);
    endtask

    task automatic toggle_speaker();
        apply_access(a2_audio_pkg::ADDR_SPEAKER, 1'b1, 1'b0);
        spk_bit_m = ~spk_bit_m;
    endtask

    task automatic set_mb();
        mb_cur = next_mb();
        mb_audio_i <= mb_cur;
    endtask

    task automatic get_word(output a2_audio_pkg::audio_sample_t w);
        while (rx_q.size() == 0) begin
            @(posedge clk_pixel_w);
        end
        w = rx_q.pop_front();
    endtask

    task automatic expect_words(input int n, input string msg);
        a2_audio_pkg::audio_sample_t w;
        for (int i = 0; i < n; i++) begin
            get_word(w);
            check_sample(w, mixed_word(mb_cur, level_m), 1'b0, msg);
            step_speaker_model();
        end
    endtask

    task automatic test_reset();
        check_softswitch(softswitch_o, '0, "reset");
        if (sample_valid_o !== 1'b0 || overflow_o !== 1'b0) begin
            $display("ERR %0t: valid %b overflow %b after reset, expected 0",
                     $time, sample_valid_o, overflow_o);
            errors++;
        end
    endtask

    task automatic test_softswitches();
        a2_audio_pkg::softswitch_t exp;
        exp = '0;
        // Odd address sets, even clears, reads and writes alike
        for (int i = 0; i < 5; i++) begin
            apply_access(switch_base(i) + 16'd1, i[0], 1'b0);
            exp[5 - i] = 1'b1;
            check_softswitch(softswitch_o, exp, "switch set");
        end
        for (int i = 0; i < 5; i++) begin
            apply_access(switch_base(i), ~i[0], 1'b0);
            exp[5 - i] = 1'b0;
            check_softswitch(softswitch_o, exp, "switch clear");
        end
        apply_access(a2_audio_pkg::ADDR_80STOREOFF + 16'd1, 1'b0, 1'b0);
        exp.store80 = 1'b1;
        check_softswitch(softswitch_o, exp, "80store write set");
        apply_access(a2_audio_pkg::ADDR_80STOREOFF, 1'b1, 1'b0);
        check_softswitch(softswitch_o, exp, "80store read");
        apply_access(a2_audio_pkg::ADDR_80STOREOFF, 1'b0, 1'b0);
        exp.store80 = 1'b0;
        check_softswitch(softswitch_o, exp, "80store write clear");
        apply_access(a2_audio_pkg::ADDR_80STOREOFF + 16'd1, 1'b1, 1'b0);
        check_softswitch(softswitch_o, exp, "80store read");
        // Not an IO page access
        apply_access(a2_audio_pkg::ADDR_TXTCLR + 16'd1, 1'b1, 1'b1);
        check_softswitch(softswitch_o, exp, "m2sel_n high");
    endtask

    task automatic test_mockingboard();
        for (int v = 0; v < 3; v++) begin
            set_mb();
            expect_words(3, "mockingboard");
        end
    endtask

    task automatic test_speaker();
        expect_words(1, "speaker sync");
        set_mb();
        toggle_speaker();
        // Two words of latency, the pulse, then plain words again
        expect_words(a2_audio_pkg::SPEAKER_PULSE_LEN + 7, "speaker pulse");
        toggle_speaker();
        expect_words(4, "speaker low");
        toggle_speaker();
        expect_words(20, "pulse start");
        toggle_speaker();
        expect_words(8, "pulse cut");
    endtask

    task automatic test_backpressure();
        a2_audio_pkg::audio_sample_t exp_q[$];
        a2_audio_pkg::audio_sample_t w;
        expect_words(1, "stall sync");
        stall_credits <= 1'b1;
        // New value each tick, words past credits plus queue depth are lost
        for (int t = 1; t <= 10; t++) begin
            set_mb();
            if (t <= a2_audio_pkg::CREDIT_MAX + a2_audio_pkg::QUEUE_DEPTH) begin
                exp_q.push_back(mixed_word(mb_cur, level_m));
            end
            step_speaker_model();
            repeat (a2_audio_pkg::AUDIO_TICK_DIV) @(posedge clk_pixel_w);
            if (t == 8 && overflow_o !== 1'b0) begin
                $display("ERR %0t: overflow set with the queue just full", $time);
                errors++;
            end
        end
        if (rx_q.size() != a2_audio_pkg::CREDIT_MAX) begin
            $display("ERR %0t: %0d words sent during credit stall, expected %0d",
                     $time, rx_q.size(), a2_audio_pkg::CREDIT_MAX);
            errors++;
        end
        stall_credits <= 1'b0;
        set_mb();
        exp_q.push_back(mixed_word(mb_cur, level_m));
        step_speaker_model();
        while (exp_q.size() != 0) begin
            get_word(w);
            check_sample(w, exp_q.pop_front(), 1'b1, "after stall");
        end
    endtask

    initial begin
        repeat (8) @(posedge clk_pixel_w);
        system_reset_n_w <= 1'b1;
        @(posedge clk_pixel_w);
        test_reset();
        test_softswitches();
        test_mockingboard();
        test_speaker();
        test_backpressure();
        errors += i_a2_audio_top.i_audio_mixer.i_a2_audio_props.fail_count;
        $display("Checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("TB FAILED");
        $finish;
    end

endmodule

//--- sim.f
common/a2_audio_pkg.sv
hw/a2_bus_decode.sv
speaker/speaker_pulse.sv
hw/audio_mixer.sv
hw/a2_audio_top.sv
test/a2_audio_props.sv
test/tb_a2_audio.sv

//--- Bender.yml
package:
  name: a2_audio

# Package first, then the RTL in dependency order
sources:
  - common/a2_audio_pkg.sv
  - hw/a2_bus_decode.sv
  - speaker/speaker_pulse.sv
  - hw/audio_mixer.sv
  - hw/a2_audio_top.sv

  # Testbench and bound properties
  - target: test
    files:
      - test/a2_audio_props.sv
      - test/tb_a2_audio.sv
